//--- list.f
conv_pkg.sv
xnor_window.sv
majority_tree.sv
row_packer.sv
sweep_ctrl.sv
conv_top.sv
conv_properties.sv
conv_tb.sv

//--- conv_tb.sv
// testbench for conv_top that runs convolution jobs from modelled memories and checks every output row
`timescale 1ns/100ps
`default_nettype none

module conv_tb;

	logic clk;
	logic reset_b;
	logic dut_run;
	logic dut_busy;
	logic [11:0] dut_sram_read_address;
	logic [15:0] sram_dut_read_data;
	logic [11:0] dut_wmem_read_address;
	logic [15:0] wmem_dut_read_data;
	logic [11:0] dut_sram_write_address;
	logic [15:0] dut_sram_write_data;
	logic dut_sram_write_enable;

	// input, weight and output memories
	logic [15:0] in_mem [0:4095];
	logic [15:0] w_mem [0:3];
	logic [15:0] out_mem [0:4095];

	// expected writes as {address, data}
	logic [27:0] exp_q[$];

	// job bookkeeping
	logic [8:0] cur_weights;
	int img_base;
	int next_waddr;

	conv_top u_dut (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.dut_busy(dut_busy),
		.dut_sram_read_address(dut_sram_read_address),
		.sram_dut_read_data(sram_dut_read_data),
		.dut_wmem_read_address(dut_wmem_read_address),
		.wmem_dut_read_data(wmem_dut_read_data),
		.dut_sram_write_address(dut_sram_write_address),
		.dut_sram_write_data(dut_sram_write_data),
		.dut_sram_write_enable(dut_sram_write_enable)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// one-cycle read latency and writes on the enable edge
	always @(posedge clk) begin
		sram_dut_read_data <= in_mem[dut_sram_read_address];
		wmem_dut_read_data <= w_mem[dut_wmem_read_address];
		if (dut_sram_write_enable) begin
			out_mem[dut_sram_write_address] <= dut_sram_write_data;
		end
	end

	task automatic abort_run();
		$display("ERRORS FOUND");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
			abort_run();
		end
	endtask

	// failures counted inside the bound checker
	task automatic stop_on_assertion_failure();
		if (u_dut.u_props.fail_count != 0) begin
			$display("%0d assertion failure(s) reported by conv_properties",
				u_dut.u_props.fail_count);
			abort_run();
		end
	endtask

	// output row i of the image at base by the majority rule
	function automatic logic [15:0] ref_row(input int base, input int i, input int cols,
		input logic [8:0] w);
		logic [15:0] word;
		int diffs;
		word = '0;
		for (int k = 0; k <= cols - 3; k++) begin
			diffs = 0;
			for (int r = 0; r < 3; r++) begin
				for (int j = 0; j < 3; j++) begin
					if (in_mem[base + 2 + i + r][k + j] != w[3 * r + j]) begin
						diffs++;
					end
				end
			end
			word[k] = (diffs <= 4);
		end
		return word;
	endfunction

	// fresh memories and weights between jobs while idle
	task automatic start_job(input logic [8:0] w);
		@(negedge clk);
		for (int a = 0; a < 4096; a++) begin
			in_mem[a] = 16'h5A00 ^ 16'(a);
			out_mem[a] = 16'hC000 ^ 16'(a);
		end
		// dimension word that the engine skips
		w_mem[0] = 16'd3;
		w_mem[1] = {7'h00, w};
		w_mem[2] = 16'h0000;
		w_mem[3] = 16'h0000;
		cur_weights = w;
		img_base = 0;
		next_waddr = 0;
		exp_q.delete();
	endtask

	// header, row words and the expected output rows of one image
	task automatic add_image(input int rows, input int cols, input bit all_ones);
		logic [15:0] mask;
		logic [15:0] word;
		mask = 16'((32'h1 << cols) - 1);
		in_mem[img_base] = 16'(rows);
		in_mem[img_base + 1] = 16'(cols);
		for (int i = 0; i < rows; i++) begin
			word = all_ones ? 16'hFFFF : 16'($urandom);
			in_mem[img_base + 2 + i] = word & mask;
		end
		for (int i = 0; i <= rows - 3; i++) begin
			exp_q.push_back({12'(next_waddr), ref_row(img_base, i, cols, cur_weights)});
			next_waddr++;
		end
		img_base += rows + 2;
	endtask

	// end marker and run pulse before waiting out the job
	task automatic run_job(input string label);
		int cycles;
		in_mem[img_base] = conv_pkg::end_marker;
		@(posedge clk);
		dut_run <= 1'b1;
		@(posedge clk);
		dut_run <= 1'b0;
		cycles = 0;
		while (!dut_busy) begin
			@(negedge clk);
			cycles++;
			if (cycles > 10) begin
				$display("%s: timed out waiting for dut_busy to rise after dut_run", label);
				abort_run();
			end
		end
		cycles = 0;
		while (dut_busy) begin
			@(negedge clk);
			cycles++;
			if (cycles > 20000) begin
				$display("%s: timed out waiting for dut_busy to drop", label);
				abort_run();
			end
		end
		// every row written before busy fell
		check_value("pending output writes", exp_q.size(), 0);
	endtask

	// compares each write with the next expected word
	always @(negedge clk) begin
		logic [27:0] item;
		if (reset_b && dut_sram_write_enable) begin
			if (exp_q.size() == 0) begin
				$display("output write to 0x%h seen when no write was expected",
					dut_sram_write_address);
				abort_run();
			end else begin
				item = exp_q.pop_front();
				check_value("dut_sram_write_address", dut_sram_write_address, item[27:16]);
				check_value("dut_sram_write_data", dut_sram_write_data, item[15:0]);
			end
		end
	end

	// bound property failures
	always @(negedge clk) begin
		stop_on_assertion_failure();
	end

	initial begin
		void'($urandom(16));
		reset_b = 1'b0;
		dut_run = 1'b0;
		sram_dut_read_data = '0;
		wmem_dut_read_data = '0;
		repeat (8) @(posedge clk);
		reset_b <= 1'b1;

		// quiet until run
		repeat (10) begin
			@(negedge clk);
			check_value("dut_busy", dut_busy, 0);
			check_value("dut_sram_write_enable", dut_sram_write_enable, 0);
		end

		// random 16x16 image with 14 rows out
		start_job(9'($urandom));
		add_image(16, 16, 1'b0);
		run_job("16x16 image");

		// 9 rows by 7 columns give 5 output bits per row
		start_job(9'($urandom));
		add_image(9, 7, 1'b0);
		run_job("9x7 image");
		for (int a = 0; a < 7; a++) begin
			check_value("out_mem bits above column 4", out_mem[a] >> 5, 0);
		end

		// three images back to back with addresses running on
		start_job(9'($urandom));
		add_image(5, 12, 1'b0);
		add_image(3, 3, 1'b0);
		add_image(7, 16, 1'b0);
		run_job("three images");
		check_value("out_mem[9]", out_mem[9], 16'hC009);

		// all-ones image against all-ones weights
		start_job(9'h1FF);
		add_image(5, 8, 1'b1);
		run_job("all-ones weights");
		for (int a = 0; a < 3; a++) begin
			check_value("out_mem", out_mem[a], 16'h003F);
		end

		// inverted weights on a second run from idle
		start_job(9'h000);
		add_image(5, 8, 1'b1);
		run_job("inverted weights");
		for (int a = 0; a < 3; a++) begin
			check_value("out_mem", out_mem[a], 16'h0000);
		end

		stop_on_assertion_failure();
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

//--- conv_properties.sv
// assertions on conv_top busy and write enable, attached to every conv_top through bind
`timescale 1ns/100ps
`default_nettype none

module conv_properties (
	input wire logic clk,
	input wire logic reset_b,
	input wire logic dut_run,
	input wire logic dut_busy,
	input wire logic dut_sram_write_enable
);

	// count of failed assertions, read by the testbench
	int fail_count;

	// writes only happen during a job
	a_write_in_busy: assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |-> dut_busy)
		else begin
			fail_count++;
			$error("write enable high while not busy");
		end

	// one write pulse per row
	a_write_single: assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |=> !dut_sram_write_enable)
		else begin
			fail_count++;
			$error("write enable high on two cycles in a row");
		end

	// busy only rises after run
	a_busy_needs_run: assert property (@(posedge clk) disable iff (!reset_b)
		(!dut_busy && !dut_run) |=> !dut_busy)
		else begin
			fail_count++;
			$error("busy rose without run");
		end

endmodule

bind conv_top conv_properties u_props (
	.clk(clk),
	.reset_b(reset_b),
	.dut_run(dut_run),
	.dut_busy(dut_busy),
	.dut_sram_write_enable(dut_sram_write_enable)
);

`default_nettype wire

//--- conv_top.sv
// binary 3x3 convolution engine top, connects the pipeline stages to the three memory ports
`timescale 1ns/100ps
`default_nettype none

module conv_top (
	input wire logic clk,
	input wire logic reset_b,
	input wire logic dut_run,
	output logic dut_busy,
	output logic [conv_pkg::addr_w-1:0] dut_sram_read_address,
	input wire logic [conv_pkg::data_w-1:0] sram_dut_read_data,
	output logic [conv_pkg::addr_w-1:0] dut_wmem_read_address,
	input wire logic [conv_pkg::data_w-1:0] wmem_dut_read_data,
	output logic [conv_pkg::addr_w-1:0] dut_sram_write_address,
	output logic [conv_pkg::data_w-1:0] dut_sram_write_data,
	output logic dut_sram_write_enable
);

	// kernel weights, stable while beats flow
	logic [conv_pkg::kernel_dim*conv_pkg::kernel_dim-1:0] weights;

	// beats between stages
	conv_pkg::col_beat_t col_beat;
	conv_pkg::match_beat_t match_beat;
	conv_pkg::result_beat_t result_beat;

	// fsm, memory reads and column beats
	sweep_ctrl u_ctrl (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.sram_dut_read_data(sram_dut_read_data),
		.wmem_dut_read_data(wmem_dut_read_data),
		.dut_busy(dut_busy),
		.dut_sram_read_address(dut_sram_read_address),
		.dut_wmem_read_address(dut_wmem_read_address),
		.weights(weights),
		.beat(col_beat)
	);

	// 3x3 window vs weights, 1 cycle
	xnor_window u_window (
		.clk(clk),
		.reset_b(reset_b),
		.weights(weights),
		.beat(col_beat),
		.match(match_beat)
	);

	// mismatch count and threshold, 2 cycles
	majority_tree u_majority (
		.clk(clk),
		.reset_b(reset_b),
		.match(match_beat),
		.result(result_beat)
	);

	// row assembly and output write
	row_packer u_packer (
		.clk(clk),
		.reset_b(reset_b),
		.result(result_beat),
		.dut_sram_write_address(dut_sram_write_address),
		.dut_sram_write_data(dut_sram_write_data),
		.dut_sram_write_enable(dut_sram_write_enable)
	);

endmodule

`default_nettype wire

//--- sweep_ctrl.sv
// controller fsm, reads image headers, weights and rows and issues one column beat per cycle
`timescale 1ns/100ps
`default_nettype none

module sweep_ctrl (
	input wire logic clk,
	input wire logic reset_b,
	input wire logic dut_run,
	input wire logic [conv_pkg::data_w-1:0] sram_dut_read_data,
	input wire logic [conv_pkg::data_w-1:0] wmem_dut_read_data,
	output logic dut_busy,
	output logic [conv_pkg::addr_w-1:0] dut_sram_read_address,
	output logic [conv_pkg::addr_w-1:0] dut_wmem_read_address,
	output logic [conv_pkg::kernel_dim*conv_pkg::kernel_dim-1:0] weights,
	output conv_pkg::col_beat_t beat
);

	conv_pkg::ctrl_state_t state;

	// image size
	logic [conv_pkg::data_w-1:0] rows;
	logic [conv_pkg::col_w-1:0] last_col;

	// rows already pulled into the window
	logic [conv_pkg::data_w-1:0] rows_loaded;

	// sweep column and output row address
	logic [conv_pkg::col_w-1:0] col;
	logic [conv_pkg::addr_w-1:0] waddr;

	// counts drain cycles up to pipe_depth
	logic [2:0] drain_cnt;

	// three-row window, row0 on top
	logic [conv_pkg::data_w-1:0] row0;
	logic [conv_pkg::data_w-1:0] row1;
	logic [conv_pkg::data_w-1:0] row2;

	// the read pointer doubles as the sram read address
	// it runs one word ahead of the data being consumed
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state <= conv_pkg::idle;
			dut_busy <= 1'b0;
			dut_sram_read_address <= '0;
			dut_wmem_read_address <= '0;
			weights <= '0;
			rows <= '0;
			last_col <= '0;
			rows_loaded <= '0;
			col <= '0;
			waddr <= '0;
			drain_cnt <= '0;
			beat <= '0;
		end else begin
			// beats last one cycle unless sweep refreshes them
			beat <= '0;
			case (state)
				conv_pkg::idle: begin
					dut_sram_read_address <= '0;
					dut_wmem_read_address <= '0;
					waddr <= '0;
					if (dut_run) begin
						state <= conv_pkg::read_rows;
						dut_busy <= 1'b1;
						// address 0 is already on the bus
						dut_sram_read_address <= conv_pkg::addr_w'(1);
						dut_wmem_read_address <= conv_pkg::weight_addr;
					end
				end
				conv_pkg::read_rows: begin
					// data is the row-count word here
					if (sram_dut_read_data == conv_pkg::end_marker) begin
						state <= conv_pkg::drain;
						drain_cnt <= '0;
					end else begin
						rows <= sram_dut_read_data;
						dut_sram_read_address <= dut_sram_read_address + 1'b1;
						state <= conv_pkg::read_cols;
					end
				end
				conv_pkg::read_cols: begin
					// 16 columns wraps to 0, minus one gives 15
					last_col <= sram_dut_read_data[conv_pkg::col_w-1:0] - 1'b1;
					// weight word arrives alongside the column count
					weights <= wmem_dut_read_data[conv_pkg::kernel_dim*conv_pkg::kernel_dim-1:0];
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					state <= conv_pkg::fill_r0;
				end
				conv_pkg::fill_r0: begin
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					state <= conv_pkg::fill_r1;
				end
				conv_pkg::fill_r1: begin
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					state <= conv_pkg::fill_r2;
				end
				conv_pkg::fill_r2: begin
					// pointer stays on row 3 for the whole sweep
					rows_loaded <= conv_pkg::data_w'(3);
					col <= '0;
					state <= conv_pkg::sweep;
				end
				conv_pkg::sweep: begin
					beat.valid <= 1'b1;
					// first two columns only prime the window
					beat.keep <= (col >= conv_pkg::col_w'(2));
					beat.row_end <= (col == last_col);
					beat.out_col <= col - conv_pkg::col_w'(2);
					beat.waddr <= waddr;
					beat.pixels <= {row2[col], row1[col], row0[col]};
					col <= col + 1'b1;
					if (col == last_col) begin
						state <= conv_pkg::next_row;
					end
				end
				conv_pkg::next_row: begin
					// data is the next row word or the next image header
					waddr <= waddr + 1'b1;
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					col <= '0;
					if (rows_loaded == rows) begin
						state <= conv_pkg::read_rows;
					end else begin
						rows_loaded <= rows_loaded + 1'b1;
						state <= conv_pkg::sweep;
					end
				end
				conv_pkg::drain: begin
					// let the last row reach the output memory
					if (drain_cnt == 3'(conv_pkg::pipe_depth)) begin
						state <= conv_pkg::idle;
						dut_busy <= 1'b0;
						dut_sram_read_address <= '0;
						dut_wmem_read_address <= '0;
					end else begin
						drain_cnt <= drain_cnt + 1'b1;
					end
				end
				default: begin
					state <= conv_pkg::idle;
				end
			endcase
		end
	end

	// row words, loaded at fill time and shifted up after each row
	always_ff @(posedge clk) begin
		case (state)
			conv_pkg::fill_r0: begin
				row0 <= sram_dut_read_data;
			end
			conv_pkg::fill_r1: begin
				row1 <= sram_dut_read_data;
			end
			conv_pkg::fill_r2: begin
				row2 <= sram_dut_read_data;
			end
			conv_pkg::next_row: begin
				// nothing to shift once the image is done
				if (rows_loaded != rows) begin
					row0 <= row1;
					row1 <= row2;
					row2 <= sram_dut_read_data;
				end
			end
			default: begin
				row0 <= row0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- row_packer.sv
// packs output bits into a row word and writes it to the output memory on the row's last bit
`timescale 1ns/100ps
`default_nettype none

module row_packer (
	input wire logic clk,
	input wire logic reset_b,
	input wire conv_pkg::result_beat_t result,
	output logic [conv_pkg::addr_w-1:0] dut_sram_write_address,
	output logic [conv_pkg::data_w-1:0] dut_sram_write_data,
	output logic dut_sram_write_enable
);

	// bits gathered so far in this row
	logic [conv_pkg::data_w-1:0] acc;
	// accumulator with the incoming bit merged in
	logic [conv_pkg::data_w-1:0] word;

	always_comb begin
		word = acc;
		if (result.valid && result.keep) begin
			word[result.out_col] = result.out_bit;
		end
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			acc <= '0;
			dut_sram_write_address <= '0;
			dut_sram_write_data <= '0;
			dut_sram_write_enable <= 1'b0;
		end else begin
			// single-cycle write pulse
			dut_sram_write_enable <= 1'b0;
			if (result.valid) begin
				if (result.row_end) begin
					// last bit goes straight into the written word
					dut_sram_write_address <= result.waddr;
					dut_sram_write_data <= word;
					dut_sram_write_enable <= 1'b1;
					// start clean, upper bits stay zero
					acc <= '0;
				end else begin
					acc <= word;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- majority_tree.sv
// two-stage full-adder tree, output bit is 1 when at most four of nine pairs differ
`timescale 1ns/100ps
`default_nettype none

module majority_tree (
	input wire logic clk,
	input wire logic reset_b,
	input wire conv_pkg::match_beat_t match,
	output conv_pkg::result_beat_t result
);

	// stage 1 partial sums, one full adder per kernel row
	logic [conv_pkg::kernel_dim-1:0] s1_ones;
	logic [conv_pkg::kernel_dim-1:0] s1_twos;
	conv_pkg::result_beat_t s1_tag;

	// stage 2 adders
	logic [1:0] sum_ones;
	logic [1:0] sum_twos;
	// mismatch count, 0..9
	logic [3:0] count;

	// returns {carry, sum}
	function automatic logic [1:0] full_add(input logic a, input logic b, input logic c);
		return {(a & b) | (a & c) | (b & c), a ^ b ^ c};
	endfunction

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			s1_ones <= '0;
			s1_twos <= '0;
			s1_tag <= '0;
		end else begin
			for (int r = 0; r < conv_pkg::kernel_dim; r++) begin
				{s1_twos[r], s1_ones[r]} <= full_add(match.mismatch[3*r],
					match.mismatch[3*r+1], match.mismatch[3*r+2]);
			end
			s1_tag.valid <= match.valid;
			s1_tag.keep <= match.keep;
			s1_tag.row_end <= match.row_end;
			s1_tag.out_col <= match.out_col;
			s1_tag.waddr <= match.waddr;
			// filled in by stage 2
			s1_tag.out_bit <= 1'b0;
		end
	end

	// ones column gives weight 1 and 2, twos column weight 2 and 4
	always_comb begin
		sum_ones = full_add(s1_ones[0], s1_ones[1], s1_ones[2]);
		sum_twos = full_add(s1_twos[0], s1_twos[1], s1_twos[2]);
		count = {3'b000, sum_ones[0]} + {2'b00, sum_ones[1], 1'b0}
			+ {2'b00, sum_twos[0], 1'b0} + {1'b0, sum_twos[1], 2'b00};
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			result <= '0;
		end else begin
			result <= s1_tag;
			// majority of matches
			result.out_bit <= (count <= 4'd4);
		end
	end

endmodule

`default_nettype wire

//--- xnor_window.sv
// 3x3 bit shift window, flags every pixel that differs from its weight, one cycle latency
`timescale 1ns/100ps
`default_nettype none

module xnor_window (
	input wire logic clk,
	input wire logic reset_b,
	input wire logic [conv_pkg::kernel_dim*conv_pkg::kernel_dim-1:0] weights,
	input wire conv_pkg::col_beat_t beat,
	output conv_pkg::match_beat_t match
);

	// win[r][j], kernel row r, kernel column j, j=2 is the newest column
	logic [conv_pkg::kernel_dim-1:0][conv_pkg::kernel_dim-1:0] win;
	logic [conv_pkg::kernel_dim-1:0][conv_pkg::kernel_dim-1:0] shifted;

	// window after taking in the incoming column
	always_comb begin
		for (int r = 0; r < conv_pkg::kernel_dim; r++) begin
			shifted[r] = {beat.pixels[r], win[r][conv_pkg::kernel_dim-1:1]};
		end
	end

	// only valid beats move the window
	always_ff @(posedge clk) begin
		if (beat.valid) begin
			win <= shifted;
		end
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			match <= '0;
		end else begin
			// tags ride along unchanged
			match.valid <= beat.valid;
			match.keep <= beat.keep;
			match.row_end <= beat.row_end;
			match.out_col <= beat.out_col;
			match.waddr <= beat.waddr;
			// mismatch bit 3*r+j pairs with weight bit 3*r+j
			for (int r = 0; r < conv_pkg::kernel_dim; r++) begin
				for (int j = 0; j < conv_pkg::kernel_dim; j++) begin
					match.mismatch[conv_pkg::kernel_dim*r+j] <=
						shifted[r][j] ^ weights[conv_pkg::kernel_dim*r+j];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- conv_pkg.sv
// shared widths, addresses, controller states and beat types, referenced by scope from every rtl file
`default_nettype none

package conv_pkg;

	// memory bus widths
	localparam int addr_w = 12;
	localparam int data_w = 16;

	// column index inside one row word
	localparam int col_w = 4;

	// kernel is fixed at 3x3
	localparam int kernel_dim = 3;

	// weight word sits at address 1, address 0 is not read
	localparam logic [addr_w-1:0] weight_addr = addr_w'(1);

	// row-count value that ends the run
	localparam logic [data_w-1:0] end_marker = 16'h00FF;

	// beat leaving sweep_ctrl to its output bit at row_packer
	localparam int pipe_depth = 3;

	// controller states
	typedef enum logic [3:0] {
		idle,
		read_rows,
		read_cols,
		fill_r0,
		fill_r1,
		fill_r2,
		sweep,
		next_row,
		drain
	} ctrl_state_t;

	// one image column of the three-row window
	typedef struct packed {
		logic valid;
		logic keep;
		logic row_end;
		logic [col_w-1:0] out_col;
		logic [addr_w-1:0] waddr;
		logic [kernel_dim-1:0] pixels;
	} col_beat_t;

	// nine pixel/weight mismatch flags, bit 3*r+j
	typedef struct packed {
		logic valid;
		logic keep;
		logic row_end;
		logic [col_w-1:0] out_col;
		logic [addr_w-1:0] waddr;
		logic [kernel_dim*kernel_dim-1:0] mismatch;
	} match_beat_t;

	// one output pixel with its position tags
	typedef struct packed {
		logic valid;
		logic keep;
		logic row_end;
		logic [col_w-1:0] out_col;
		logic [addr_w-1:0] waddr;
		logic out_bit;
	} result_beat_t;

endpackage

`default_nettype wire
